// File: hw/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// Cache geometry
`define ICACHE_LINES      128
`define ICACHE_WORDS      16
`define ICACHE_WORD_W     32

// Physical address split
// tag    [31:13]
// index  [12:6]
// offset [5:2]
`define ICACHE_ADDR_W     32
`define ICACHE_TAG_W      19
`define ICACHE_TAG_LSB    13
`define ICACHE_INDEX_W    7
`define ICACHE_INDEX_LSB  6
`define ICACHE_OFFSET_W   4
`define ICACHE_OFFSET_LSB 2

`endif

// File: hw/icache_pkg.sv
`include "icache_consts.svh"

package icache_pkg;

    // Controller states
    typedef enum logic [2:0] {
        IDLE            = 3'b000,
        CACHED_SHAKE    = 3'b001,
        CACHED_WAIT     = 3'b010,
        CACHED_REFILL   = 3'b011,
        UNCACHED_SHAKE  = 3'b101,
        UNCACHED_RETURN = 3'b110
    } icache_state_e;

    // One instruction word
    typedef logic [`ICACHE_WORD_W-1:0] word_t;

    // Full line with word 0 in the low bits
    typedef logic [`ICACHE_WORDS-1:0][`ICACHE_WORD_W-1:0] line_t;

endpackage

// File: hw/icache_ctrl_fsm.sv
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_ctrl_fsm (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      ien,
    input  logic                      iaddr_type, // 1 = uncached
    input  logic [`ICACHE_ADDR_W-1:0] iaddr_psy,
    input  logic                      hit,
    input  logic                      idata_rvalid,
    input  logic                      idata_rlast,
    input  logic                      iaddr_req_ok,
    output logic                      read_en,
    output logic                      read_type,  // 1 = refill burst
    output logic [`ICACHE_ADDR_W-1:0] iaddr_req,
    output logic                      beat_en,
    output logic                      beat_clear,
    output logic                      buf_we,
    output logic                      store_we,
    output logic                      use_buffer,
    output logic                      pass_through,
    output logic                      inst_ok,
    output logic                      inst_ok_1,
    output logic                      inst_ok_2,
    output icache_pkg::icache_state_e state
);

    import icache_pkg::*;

    icache_state_e                next_state;
    logic                         last_word;
    logic [`ICACHE_ADDR_W-1:0]    line_addr;

    assign last_word = &iaddr_psy[`ICACHE_OFFSET_LSB +: `ICACHE_OFFSET_W];
    assign line_addr = {iaddr_psy[`ICACHE_ADDR_W-1:`ICACHE_INDEX_LSB],
                        {`ICACHE_INDEX_LSB{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_comb begin
        next_state   = state;
        read_en      = 1'b0;
        read_type    = 1'b0;
        iaddr_req    = '0;
        store_we     = 1'b0;
        use_buffer   = 1'b0;
        pass_through = 1'b0;
        inst_ok      = 1'b0;
        inst_ok_1    = 1'b0;
        inst_ok_2    = 1'b0;

        case (state)
            IDLE: begin
                if (ien && iaddr_type) begin
                    read_en    = 1'b1;
                    iaddr_req  = iaddr_psy; // Exact address for a single beat
                    next_state = iaddr_req_ok ? UNCACHED_RETURN : UNCACHED_SHAKE;
                end else if (ien && hit) begin
                    inst_ok    = 1'b1;
                    inst_ok_1  = 1'b1;
                    inst_ok_2  = !last_word;
                end else if (ien) begin
                    read_en    = 1'b1;
                    read_type  = 1'b1;
                    iaddr_req  = line_addr;
                    next_state = iaddr_req_ok ? CACHED_WAIT : CACHED_SHAKE;
                end
            end
            CACHED_SHAKE: begin
                read_en   = 1'b1;
                read_type = 1'b1;
                iaddr_req = line_addr;
                if (iaddr_req_ok)
                    next_state = CACHED_WAIT;
            end
            CACHED_WAIT: begin
                if (idata_rvalid && idata_rlast)
                    next_state = CACHED_REFILL;
            end
            CACHED_REFILL: begin
                store_we   = 1'b1;
                use_buffer = 1'b1; // Answer from the fresh line
                inst_ok    = 1'b1;
                inst_ok_1  = 1'b1;
                inst_ok_2  = !last_word;
                next_state = IDLE;
            end
            UNCACHED_SHAKE: begin
                read_en   = 1'b1;
                iaddr_req = iaddr_psy;
                if (iaddr_req_ok)
                    next_state = UNCACHED_RETURN;
            end
            UNCACHED_RETURN: begin
                pass_through = 1'b1;
                inst_ok      = idata_rvalid;
                inst_ok_1    = idata_rvalid;
                if (idata_rvalid && idata_rlast)
                    next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    // Beat counting only during the refill burst
    assign beat_en    = (state == CACHED_WAIT) && idata_rvalid;
    assign buf_we     = beat_en;
    assign beat_clear = (state == IDLE);

    a_read_en_state: assert property (
        @(posedge clk) disable iff (rst)
        read_en |-> state inside {IDLE, CACHED_SHAKE, UNCACHED_SHAKE}
    );

    // Request held stable until accepted
    a_req_hold: assert property (
        @(posedge clk) disable iff (rst)
        read_en && !iaddr_req_ok |=> read_en && $stable(iaddr_req)
    );

    a_store_we_pulse: assert property (
        @(posedge clk) disable iff (rst)
        store_we |=> !store_we
    );

endmodule

// File: hw/refill_beat_counter.sv
`timescale 1ns/1ns
`include "icache_consts.svh"

module refill_beat_counter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        beat_clear,
    input  logic                        beat_en,
    output logic [`ICACHE_OFFSET_W-1:0] beat_idx
);

    logic wrapped; // All 16 beats seen since the last clear

    always_ff @(posedge clk) begin
        if (rst || beat_clear) begin
            beat_idx <= '0;
            wrapped  <= 1'b0;
        end else if (beat_en) begin
            beat_idx <= beat_idx + 1'b1; // Wraps at 16
            if (&beat_idx)
                wrapped <= 1'b1;
        end
    end

    // A refill never delivers a 17th beat
    a_no_extra_beat: assert property (
        @(posedge clk) disable iff (rst)
        !(beat_en && wrapped && beat_idx == '0)
    );

endmodule

// File: hw/refill_line_buffer.sv
`timescale 1ns/1ns
`include "icache_consts.svh"

module refill_line_buffer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        buf_we,
    input  logic [`ICACHE_OFFSET_W-1:0] beat_idx,
    input  icache_pkg::word_t           idata_rdata,
    input  logic                        use_buffer,
    input  logic                        pass_through,
    input  logic [`ICACHE_OFFSET_W-1:0] offset,
    input  icache_pkg::line_t           rd_line,
    output icache_pkg::line_t           wr_line,
    output icache_pkg::word_t           inst_data_1,
    output icache_pkg::word_t           inst_data_2
);

    import icache_pkg::*;

    line_t                       buf_line;
    line_t                       src_line;
    logic [`ICACHE_OFFSET_W-1:0] next_offset;
    logic                        last_word;

    // Refill beats land in order of arrival
    always_ff @(posedge clk) begin
        if (buf_we)
            buf_line[beat_idx] <= idata_rdata;
    end

    assign wr_line     = buf_line;
    assign src_line    = use_buffer ? buf_line : rd_line;
    assign next_offset = offset + 1'b1;
    assign last_word   = &offset;

    always_comb begin
        if (pass_through) begin
            inst_data_1 = idata_rdata; // Uncached beat goes straight out
            inst_data_2 = '0;
        end else begin
            inst_data_1 = src_line[offset];
            inst_data_2 = last_word ? '0 : src_line[next_offset];
        end
    end

    // Buffer fill and uncached return are separate phases
    a_fill_not_passthru: assert property (
        @(posedge clk) disable iff (rst)
        !(buf_we && pass_through)
    );

    // Answer from the buffer only after a completed fill
    a_buffer_after_fill: assert property (
        @(posedge clk) disable iff (rst)
        $rose(use_buffer) |-> $past(buf_we)
    );

endmodule

// File: hw/icache_store.sv
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_store (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`ICACHE_INDEX_W-1:0] index,
    input  logic [`ICACHE_TAG_W-1:0]   tag,
    input  logic                       store_we,
    input  icache_pkg::line_t          wr_line,
    output logic                       hit,
    output icache_pkg::line_t          rd_line
);

    import icache_pkg::*;

    logic [`ICACHE_LINES-1:0] valid;
    logic [`ICACHE_TAG_W-1:0] tag_mem  [`ICACHE_LINES];
    line_t                    data_mem [`ICACHE_LINES];

    always_ff @(posedge clk) begin
        if (rst)
            valid <= '0;
        else if (store_we)
            valid[index] <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (store_we) begin
            tag_mem[index]  <= tag;
            data_mem[index] <= wr_line;
        end
    end

    // Async read so a hit resolves in the request cycle
    assign rd_line = data_mem[index];
    assign hit     = valid[index] && (tag_mem[index] == tag);

endmodule

// File: hw/icache_top.sv
`timescale 1ns/1ns
`include "icache_consts.svh"

module icache_top (
    input  logic                      clk,
    input  logic                      rst,

    // Core side
    input  logic                      ien,
    input  logic [`ICACHE_ADDR_W-1:0] iaddr_psy,
    input  logic                      iaddr_type,
    output logic                      inst_ok,
    output logic                      inst_ok_1,
    output logic                      inst_ok_2,
    output icache_pkg::word_t         inst_data_1,
    output icache_pkg::word_t         inst_data_2,

    // Memory side
    output logic [`ICACHE_ADDR_W-1:0] iaddr_req,
    output logic                      read_en,
    output logic                      read_type,
    input  logic                      iaddr_req_ok,
    input  icache_pkg::word_t         idata_rdata,
    input  logic                      idata_rvalid,
    input  logic                      idata_rlast
);

    import icache_pkg::*;

    logic [`ICACHE_TAG_W-1:0]    tag;
    logic [`ICACHE_INDEX_W-1:0]  index;
    logic [`ICACHE_OFFSET_W-1:0] offset;

    logic                        hit;
    logic                        beat_en;
    logic                        beat_clear;
    logic [`ICACHE_OFFSET_W-1:0] beat_idx;
    logic                        buf_we;
    logic                        store_we;
    logic                        use_buffer;
    logic                        pass_through;
    line_t                       rd_line;
    line_t                       wr_line;
    icache_state_e               state;

    assign tag    = iaddr_psy[`ICACHE_TAG_LSB    +: `ICACHE_TAG_W];
    assign index  = iaddr_psy[`ICACHE_INDEX_LSB  +: `ICACHE_INDEX_W];
    assign offset = iaddr_psy[`ICACHE_OFFSET_LSB +: `ICACHE_OFFSET_W];

    icache_ctrl_fsm u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .ien          (ien),
        .iaddr_type   (iaddr_type),
        .iaddr_psy    (iaddr_psy),
        .hit          (hit),
        .idata_rvalid (idata_rvalid),
        .idata_rlast  (idata_rlast),
        .iaddr_req_ok (iaddr_req_ok),
        .read_en      (read_en),
        .read_type    (read_type),
        .iaddr_req    (iaddr_req),
        .beat_en      (beat_en),
        .beat_clear   (beat_clear),
        .buf_we       (buf_we),
        .store_we     (store_we),
        .use_buffer   (use_buffer),
        .pass_through (pass_through),
        .inst_ok      (inst_ok),
        .inst_ok_1    (inst_ok_1),
        .inst_ok_2    (inst_ok_2),
        .state        (state)
    );

    refill_beat_counter u_counter (
        .clk        (clk),
        .rst        (rst),
        .beat_clear (beat_clear),
        .beat_en    (beat_en),
        .beat_idx   (beat_idx)
    );

    refill_line_buffer u_buffer (
        .clk          (clk),
        .rst          (rst),
        .buf_we       (buf_we),
        .beat_idx     (beat_idx),
        .idata_rdata  (idata_rdata),
        .use_buffer   (use_buffer),
        .pass_through (pass_through),
        .offset       (offset),
        .rd_line      (rd_line),
        .wr_line      (wr_line),
        .inst_data_1  (inst_data_1),
        .inst_data_2  (inst_data_2)
    );

    icache_store u_store (
        .clk      (clk),
        .rst      (rst),
        .index    (index),
        .tag      (tag),
        .store_we (store_we),
        .wr_line  (wr_line),
        .hit      (hit),
        .rd_line  (rd_line)
    );

    // Refill ends only after exactly 16 beats
    a_refill_complete: assert property (
        @(posedge clk) disable iff (rst)
        state == CACHED_REFILL |-> beat_idx == '0
    );

endmodule

// File: tests/tb_mem_model.sv
`timescale 1ns/1ns

module tb_mem_model #(
    parameter int SEED    = 1,
    parameter int WORDS_W = 13 // 32 KB word-addressed window
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] iaddr_req,
    input  logic        read_en,
    input  logic        read_type,
    output logic        iaddr_req_ok,
    output logic [31:0] idata_rdata,
    output logic        idata_rvalid,
    output logic        idata_rlast
);

    localparam int WORDS = 1 << WORDS_W;

    logic [31:0] words [WORDS];
    int          seed   = SEED;
    logic        busy   = 1'b0;
    logic [31:0] base   = '0;
    int          beats  = 0;
    int          sent   = 0;
    int          waited = 0;
    int          delay  = 0; // Cycles before iaddr_req_ok rises

    // Request acceptance and beat count
    always @(posedge clk) begin
        if (rst) begin
            busy   = 1'b0;
            waited = 0;
        end else if (!busy && read_en && iaddr_req_ok) begin
            busy  = 1'b1;
            base  = iaddr_req;
            beats = read_type ? 16 : 1;
            sent  = 0;
        end else if (!busy && read_en) begin
            waited++;
        end else if (busy && idata_rvalid) begin
            sent++;
            if (idata_rlast) begin
                busy   = 1'b0;
                waited = 0;
                delay  = $unsigned($random(seed)) % 4;
            end
        end
    end

    initial begin
        logic [31:0] waddr;
        for (int i = 0; i < WORDS; i++)
            words[i[WORDS_W-1:0]] = (i * 32'h9E37_79B1) ^ 32'h5A3C_0F96;
        iaddr_req_ok = 1'b0;
        idata_rdata  = '0;
        idata_rvalid = 1'b0;
        idata_rlast  = 1'b0;
        forever begin
            @(negedge clk);
            iaddr_req_ok = !busy && (waited >= delay);
            idata_rvalid = 1'b0;
            idata_rlast  = 1'b0;
            if (busy && ($unsigned($random(seed)) % 3 != 0)) begin // Random beat gaps
                waddr        = {2'b00, base[31:2]} + sent;
                idata_rvalid = 1'b1;
                idata_rdata  = words[waddr[WORDS_W-1:0]];
                idata_rlast  = (sent == beats - 1);
            end
        end
    end

endmodule

// File: tests/tb_icache.sv
`timescale 1ns/1ns

module tb_icache;

    import icache_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 16;
    localparam int TIMEOUT    = 200; // Cycles allowed per fetch
    localparam int SEED       = 57;

    logic        clk;
    logic        rst;
    logic        ien;
    logic        iaddr_type;
    logic [31:0] iaddr_psy;
    logic        inst_ok, inst_ok_1, inst_ok_2;
    word_t       inst_data_1, inst_data_2;
    logic [31:0] iaddr_req;
    logic        read_en, read_type, iaddr_req_ok;
    word_t       idata_rdata;
    logic        idata_rvalid, idata_rlast;

    int          errors;
    int          mark; // Error count when the current test began
    int          tests_run;
    int          tests_failed;
    logic        timed_out; // A fetch never completed

    // Last fetch as seen on the ports
    logic        saw_req;
    logic        req_type;
    logic [31:0] req_addr;
    logic        got_ok_1, got_ok_2;
    word_t       got_1, got_2;
    int          latency;

    icache_top DUT (.*);

    tb_mem_model #(.SEED(SEED)) mem (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic word_t expected_word(input logic [31:0] addr);
        return mem.words[addr[14:2]];
    endfunction

    task automatic compare(input string name, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("mismatch %s %s: expected %h, actual %h", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic end_run();
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != mark) begin
            tests_failed++;
            $display("FAIL %s with %0d errors", name, errors - mark);
        end else if (timed_out) begin
            $display("SKIP %s after an earlier fetch hung", name);
        end else begin
            $display("PASS %s", name);
        end
        mark = errors;
    endtask

    // Holds the address until inst_ok and samples a quarter period after each falling edge
    task automatic fetch(input string name, input logic [31:0] addr, input logic uncached);
        int cycles;
        cycles  = 0;
        saw_req = 1'b0;
        @(negedge clk);
        ien        = 1'b1;
        iaddr_psy  = addr;
        iaddr_type = uncached;
        #(CLK_PERIOD / 4);
        while (cycles < TIMEOUT) begin
            if (read_en && !saw_req) begin
                saw_req  = 1'b1;
                req_addr = iaddr_req;
                req_type = read_type;
            end
            if (inst_ok)
                break;
            @(negedge clk);
            #(CLK_PERIOD / 4);
            cycles++;
        end
        if (!inst_ok) begin
            $display("%s: fetch of %h got no answer within %0d cycles", name, addr, TIMEOUT);
            errors++;
            timed_out = 1'b1;
        end else begin
            latency  = cycles;
            got_ok_1 = inst_ok_1;
            got_ok_2 = inst_ok_2;
            got_1    = inst_data_1;
            got_2    = inst_data_2;
            @(negedge clk);
            ien        = 1'b0;
            iaddr_type = 1'b0;
            #(CLK_PERIOD / 4);
            compare(name, "read_en when idle", 32'h0, 32'(read_en));
        end
    endtask

    task automatic check_fetch(input string name, input logic [31:0] addr,
                               input logic uncached, input logic miss);
        logic last;
        last = &addr[5:2];
        if (timed_out)
            return;
        fetch(name, addr, uncached);
        if (timed_out)
            return;
        compare(name, "read_en seen", 32'(miss), 32'(saw_req));
        if (miss) begin
            compare(name, "iaddr_req", uncached ? addr : {addr[31:6], 6'b0}, req_addr);
            compare(name, "read_type", 32'(!uncached), 32'(req_type));
        end else begin
            compare(name, "latency", 32'h0, latency);
        end
        compare(name, "inst_ok_1", 32'h1, 32'(got_ok_1));
        compare(name, "inst_ok_2", 32'(!uncached && !last), 32'(got_ok_2));
        compare(name, "inst_data_1", expected_word(addr), got_1);
        if (!uncached)
            compare(name, "inst_data_2", last ? 32'h0 : expected_word(addr + 32'd4), got_2);
    endtask

    initial begin
        int i;
        int k;
        timed_out  = 1'b0;
        rst        = 1'b1;
        ien        = 1'b0;
        iaddr_type = 1'b0;
        iaddr_psy  = '0;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        #(CLK_PERIOD / 4);
        compare("reset", "read_en", 32'h0, 32'(read_en));
        compare("reset", "inst_ok", 32'h0, 32'(inst_ok));
        compare("reset", "inst_ok_1", 32'h0, 32'(inst_ok_1));
        compare("reset", "inst_ok_2", 32'h0, 32'(inst_ok_2));
        finish_test("reset");

        check_fetch("cold_miss", 32'h0000_1A48, 1'b0, 1'b1);
        finish_test("cold_miss");

        check_fetch("hit_after_refill", 32'h0000_1A64, 1'b0, 1'b0);
        check_fetch("hit_after_refill", 32'h0000_1A40, 1'b0, 1'b0);
        finish_test("hit_after_refill");

        check_fetch("end_of_line", 32'h0000_0BFC, 1'b0, 1'b1);
        check_fetch("end_of_line", 32'h0000_0BFC, 1'b0, 1'b0);
        finish_test("end_of_line");

        check_fetch("uncached", 32'h0000_3124, 1'b1, 1'b1);
        check_fetch("uncached", 32'h0000_3124, 1'b1, 1'b1);
        finish_test("uncached");

        // Index 17 with tags 0 and 1
        for (i = 0; i < 4; i++)
            check_fetch("conflict", i[0] ? 32'h0000_2444 : 32'h0000_0444, 1'b0, 1'b1);
        finish_test("conflict");

        // Sixteen distinct indices at offsets 0 to 15 and then the same set as hits
        for (i = 0; i < 2; i++) begin
            for (k = 0; k < 16; k++)
                check_fetch("back_pressure", 32'h0000_4000 + k * 452, 1'b0, i == 0);
        end
        finish_test("back_pressure");

        end_run();
    end

endmodule

// File: icache_top.f
+incdir+hw
hw/icache_pkg.sv
hw/icache_ctrl_fsm.sv
hw/refill_beat_counter.sv
hw/refill_line_buffer.sv
hw/icache_store.sv
hw/icache_top.sv
tests/tb_mem_model.sv
tests/tb_icache.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_icache
RTL_TOP   ?= icache_top
FILELIST  ?= icache_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing --assert
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
